/* axi_wslv_pkg.sv */
/*
 * Widths, buffer depths and codes shared by the AXI4 write slave front end.
 * The data bus is fixed at 32 bits. WRAP bursts are not supported and have no code.
 */
package axi_wslv_pkg;

    // ------------------------------------------------------------------------
    // AXI bus widths
    // ------------------------------------------------------------------------
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    // Largest legal AWSIZE, one full data word per beat
    localparam int BYTES_LOG2 = $clog2(STRB_W);
    localparam int ADDR_W     = 32;
    localparam int ID_W       = 4;
    localparam int LEN_W      = 8;
    localparam int SIZE_W     = 3;
    localparam int BURST_W    = 2;
    localparam int RESP_W     = 2;

    // ------------------------------------------------------------------------
    // Buffers
    // ------------------------------------------------------------------------
    localparam int AW_DEPTH   = 4;
    localparam int W_DEPTH    = 16;
    localparam int B_DEPTH    = 4;
    // Packed words, fields in AXI order
    localparam int AW_WORD_W  = ID_W + ADDR_W + LEN_W + SIZE_W + BURST_W;
    localparam int W_WORD_W   = DATA_W + STRB_W + 1;
    localparam int B_WORD_W   = ID_W + RESP_W;

    // Burst types, RESERVED is handled as INCR
    localparam logic [BURST_W-1:0] BT_FIXED = BURST_W'(0);
    localparam logic [BURST_W-1:0] BT_INCR  = BURST_W'(1);

    localparam logic [RESP_W-1:0] RESP_OKAY   = RESP_W'(0);
    localparam logic [RESP_W-1:0] RESP_SLVERR = RESP_W'(2);

    // Controller phases
    localparam int PHASE_W = 2;
    localparam logic [PHASE_W-1:0] PH_FIRST = 2'd0;
    localparam logic [PHASE_W-1:0] PH_BURST = 2'd1;
    localparam logic [PHASE_W-1:0] PH_BRESP = 2'd2;
    localparam logic [PHASE_W-1:0] PH_IDLE  = 2'd3;

    // 4 KB page boundary
    localparam int PAGE_BIT = 12;

endpackage

/* burst_addr_if.sv */
/*
 * Burst header from the controller to the address generator and beat addresses back.
 * load and advance are single-cycle pulses and never occur together.
 */
interface burst_addr_if;
    import axi_wslv_pkg::*;

    // Header of the burst in flight
    logic [ADDR_W-1:0]  start_addr;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
    // Beat 0 issued of a burst with more beats to follow
    logic               load;
    // Any later beat issued
    logic               advance;

    // Beat 0 address and running address of later beats
    logic [ADDR_W-1:0]  first_addr;
    logic [ADDR_W-1:0]  beat_addr;

    modport ctrl (
        output start_addr, size, burst, load, advance,
        input  first_addr, beat_addr
    );

    modport gen (
        input  start_addr, size, burst, load, advance,
        output first_addr, beat_addr
    );

endinterface

/* sync_fifo.sv */
/*
 * Show-ahead FIFO. The head word is valid whenever empty is low.
 * A push is visible at head one cycle later. A push while full is illegal.
 */
module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Storage array
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // Callers must respect the flags
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

/* burst_addr_gen.sv */
/*
 * Beat address generator for FIXED and INCR bursts. WRAP and RESERVED step like INCR.
 * Sizes wider than the bus are addressed as full-word beats.
 * A step that would leave the 4 KB page repeats the previous address.
 */
module burst_addr_gen (
    input  logic      clk,
    input  logic      rst_n,
    burst_addr_if.gen addr_bus
);
    import axi_wslv_pkg::*;

    logic [SIZE_W-1:0] eff_size;
    logic [ADDR_W-1:0] size_mask;
    logic [ADDR_W-1:0] aligned_addr;
    logic [ADDR_W-1:0] step;
    logic [ADDR_W-1:0] base_addr;
    logic [ADDR_W-1:0] cand_addr;
    logic [ADDR_W-1:0] next_addr;
    logic [ADDR_W-1:0] beat_q;

    // ------------------------------------------------------------------------
    // Size decode
    // ------------------------------------------------------------------------
    // Clamp to the bus width. The controller flags the error separately.
    assign eff_size = (addr_bus.size > SIZE_W'(BYTES_LOG2)) ?
                      SIZE_W'(BYTES_LOG2) : addr_bus.size;

    // Low address bits below the transfer size are cleared
    assign size_mask    = {ADDR_W{1'b1}} << eff_size;
    assign aligned_addr = addr_bus.start_addr & size_mask;

    always_comb begin
        case (addr_bus.burst)
            BT_FIXED: step = '0;
            // INCR step, also taken by WRAP and RESERVED
            default:  step = ADDR_W'(1) << eff_size;
        endcase
    end

    // ------------------------------------------------------------------------
    // Running beat address
    // ------------------------------------------------------------------------
    // Beat 1 steps from the aligned start, later beats from the last address
    assign base_addr = addr_bus.load ? aligned_addr : beat_q;
    assign cand_addr = base_addr + step;

    // Page bit differs from the start address, so the address is held
    assign next_addr = (cand_addr[PAGE_BIT] != addr_bus.start_addr[PAGE_BIT]) ?
                       base_addr : cand_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= '0;
        end else if (addr_bus.load || addr_bus.advance) begin
            beat_q <= next_addr;
        end
    end

    // Beat 0 keeps the unaligned address
    assign addr_bus.first_addr = addr_bus.start_addr;
    assign addr_bus.beat_addr  = beat_q;

endmodule

/* wburst_ctrl.sv */
/*
 * Replays buffered AXI write bursts to the user port, one beat per granted cycle.
 * Beat 0 needs both AW and W heads. The response is pushed on the last beat,
 * or later in PH_BRESP while the B buffer is full. WLAST must match AWLEN.
 */
module wburst_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [axi_wslv_pkg::AW_WORD_W-1:0]  aw_head,
    input  logic                                aw_empty,
    output logic                                aw_pop,
    input  logic [axi_wslv_pkg::W_WORD_W-1:0]   w_head,
    input  logic                                w_empty,
    output logic                                w_pop,
    input  logic                                b_full,
    output logic                                b_push,
    output logic [axi_wslv_pkg::B_WORD_W-1:0]   b_word,
    input  logic                                grant,
    burst_addr_if.ctrl                          addr_bus,
    output logic                                user_we,
    output logic [axi_wslv_pkg::ID_W-1:0]       user_id,
    output logic [axi_wslv_pkg::ADDR_W-1:0]     user_addr,
    output logic [axi_wslv_pkg::DATA_W-1:0]     user_data,
    output logic [axi_wslv_pkg::STRB_W-1:0]     user_strb,
    output logic                                user_last
);
    import axi_wslv_pkg::*;

    // Buffer head fields
    logic [ID_W-1:0]    hd_id;
    logic [ADDR_W-1:0]  hd_addr;
    logic [LEN_W-1:0]   hd_len;
    logic [SIZE_W-1:0]  hd_size;
    logic [BURST_W-1:0] hd_burst;
    logic [DATA_W-1:0]  w_data;
    logic [STRB_W-1:0]  w_strb;
    logic               w_last;
    // Header held for the rest of the burst
    logic [ID_W-1:0]    id_q;
    logic [ADDR_W-1:0]  addr_q;
    logic [LEN_W-1:0]   len_q;
    logic [SIZE_W-1:0]  size_q;
    logic [BURST_W-1:0] burst_q;
    logic [ID_W-1:0]    cur_id;
    logic [SIZE_W-1:0]  cur_size;
    logic [PHASE_W-1:0] phase_q;
    logic [PHASE_W-1:0] phase_d;
    logic [LEN_W-1:0]   beat_cnt;
    logic               in_first;
    logic               first_issue;
    logic               burst_issue;
    logic               beat_issue;
    logic               burst_last;
    logic [RESP_W-1:0]  resp;

    assign {hd_id, hd_addr, hd_len, hd_size, hd_burst} = aw_head;
    assign {w_data, w_strb, w_last} = w_head;

    // ------------------------------------------------------------------------
    // Beat issue
    // ------------------------------------------------------------------------
    assign in_first    = (phase_q == PH_FIRST);
    assign first_issue = in_first && !aw_empty && !w_empty && grant;
    assign burst_issue = (phase_q == PH_BURST) && !w_empty && grant;
    assign beat_issue  = first_issue || burst_issue;

    // Single-beat bursts end on beat 0
    assign burst_last = (first_issue && hd_len == '0) ||
                        (burst_issue && beat_cnt == len_q);

    assign aw_pop = first_issue;
    assign w_pop  = beat_issue;

    // Head fields in PH_FIRST, held copy after that
    assign cur_id   = in_first ? hd_id : id_q;
    assign cur_size = in_first ? hd_size : size_q;

    always_ff @(posedge clk) begin
        if (aw_pop) begin
            id_q    <= hd_id;
            addr_q  <= hd_addr;
            len_q   <= hd_len;
            size_q  <= hd_size;
            burst_q <= hd_burst;
        end
    end

    // Beat 0 counts as one, so the last beat sees len
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (first_issue) begin
            beat_cnt <= LEN_W'(1);
        end else if (burst_issue) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Phase machine
    // ------------------------------------------------------------------------
    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PH_IDLE: phase_d = PH_FIRST;
            PH_FIRST: begin
                if (first_issue && hd_len != '0) begin
                    phase_d = PH_BURST;
                end else if (burst_last && b_full) begin
                    phase_d = PH_BRESP;
                end
            end
            PH_BURST: begin
                if (burst_last) begin
                    phase_d = b_full ? PH_BRESP : PH_FIRST;
                end
            end
            // Wait for room in the B buffer
            PH_BRESP: begin
                if (!b_full) begin
                    phase_d = PH_FIRST;
                end
            end
            default: phase_d = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= PH_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    // Response
    assign resp   = (cur_size > SIZE_W'(BYTES_LOG2)) ? RESP_SLVERR : RESP_OKAY;
    assign b_push = !b_full && (burst_last || phase_q == PH_BRESP);
    assign b_word = {cur_id, resp};

    // Address generator
    assign addr_bus.start_addr = in_first ? hd_addr : addr_q;
    assign addr_bus.size       = cur_size;
    assign addr_bus.burst      = in_first ? hd_burst : burst_q;
    assign addr_bus.load       = first_issue && hd_len != '0;
    assign addr_bus.advance    = burst_issue;

    // User write port
    assign user_we   = beat_issue;
    assign user_id   = cur_id;
    assign user_addr = in_first ? addr_bus.first_addr : addr_bus.beat_addr;
    assign user_data = w_data;
    assign user_strb = beat_issue ? w_strb : '0;
    assign user_last = beat_issue ? w_last : 1'b0;

    // Arbiter grant is honoured on every beat
    a_we_granted: assert property (@(posedge clk) disable iff (!rst_n) user_we |-> grant);
    // Master WLAST agrees with the AWLEN beat count
    a_wlast_len: assert property (@(posedge clk) disable iff (!rst_n)
        user_we |-> (w_last == burst_last));

endmodule

/* axi_wslv.sv */
/*
 * AXI4 write slave front end on a single clock. Bursts reach the user port only
 * while grant is high. Responses come back in order, SLVERR for oversized transfers.
 */
module axi_wslv (
    input  logic                               clk,
    input  logic                               rst_n,
    // AW channel
    input  logic [axi_wslv_pkg::ID_W-1:0]      awid,
    input  logic [axi_wslv_pkg::ADDR_W-1:0]    awaddr,
    input  logic [axi_wslv_pkg::LEN_W-1:0]     awlen,
    input  logic [axi_wslv_pkg::SIZE_W-1:0]    awsize,
    input  logic [axi_wslv_pkg::BURST_W-1:0]   awburst,
    input  logic                               awvalid,
    output logic                               awready,
    // W channel
    input  logic [axi_wslv_pkg::DATA_W-1:0]    wdata,
    input  logic [axi_wslv_pkg::STRB_W-1:0]    wstrb,
    input  logic                               wlast,
    input  logic                               wvalid,
    output logic                               wready,
    // B channel
    output logic [axi_wslv_pkg::ID_W-1:0]      bid,
    output logic [axi_wslv_pkg::RESP_W-1:0]    bresp,
    output logic                               bvalid,
    input  logic                               bready,
    // User write port
    input  logic                               grant,
    output logic                               user_we,
    output logic [axi_wslv_pkg::ID_W-1:0]      user_id,
    output logic [axi_wslv_pkg::ADDR_W-1:0]    user_addr,
    output logic [axi_wslv_pkg::DATA_W-1:0]    user_data,
    output logic [axi_wslv_pkg::STRB_W-1:0]    user_strb,
    output logic                               user_last
);
    import axi_wslv_pkg::*;

    logic [AW_WORD_W-1:0] aw_head;
    logic                 aw_full;
    logic                 aw_empty;
    logic                 aw_pop;
    logic [W_WORD_W-1:0]  w_head;
    logic                 w_full;
    logic                 w_empty;
    logic                 w_pop;
    logic [B_WORD_W-1:0]  b_word;
    logic [B_WORD_W-1:0]  b_head;
    logic                 b_full;
    logic                 b_empty;
    logic                 b_push;

    burst_addr_if addr_bus ();

    // AXI handshakes follow the buffer flags
    assign awready = !aw_full;
    assign wready  = !w_full;
    assign bvalid  = !b_empty;
    assign {bid, bresp} = b_head;

    sync_fifo #(.WIDTH(AW_WORD_W), .DEPTH(AW_DEPTH)) aw_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (awvalid && awready),
        .din   ({awid, awaddr, awlen, awsize, awburst}),
        .full  (aw_full),
        .pop   (aw_pop),
        .head  (aw_head),
        .empty (aw_empty)
    );

    sync_fifo #(.WIDTH(W_WORD_W), .DEPTH(W_DEPTH)) w_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (wvalid && wready),
        .din   ({wdata, wstrb, wlast}),
        .full  (w_full),
        .pop   (w_pop),
        .head  (w_head),
        .empty (w_empty)
    );

    sync_fifo #(.WIDTH(B_WORD_W), .DEPTH(B_DEPTH)) b_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (b_push),
        .din   (b_word),
        .full  (b_full),
        .pop   (bvalid && bready),
        .head  (b_head),
        .empty (b_empty)
    );

    wburst_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw_head   (aw_head),
        .aw_empty  (aw_empty),
        .aw_pop    (aw_pop),
        .w_head    (w_head),
        .w_empty   (w_empty),
        .w_pop     (w_pop),
        .b_full    (b_full),
        .b_push    (b_push),
        .b_word    (b_word),
        .grant     (grant),
        .addr_bus  (addr_bus),
        .user_we   (user_we),
        .user_id   (user_id),
        .user_addr (user_addr),
        .user_data (user_data),
        .user_strb (user_strb),
        .user_last (user_last)
    );

    burst_addr_gen u_addr_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr_bus (addr_bus)
    );

endmodule

/* tb_axi_wslv.sv */
/*
 * Testbench for the AXI4 write slave front end. Runs from the project root and
 * reads axi_wslv_golden.txt there. One burst is in flight on the AXI side at a
 * time, and responses are checked in issue order against the golden table.
 */
module tb_axi_wslv;
    timeunit 1ns;
    timeprecision 1ps;
    import axi_wslv_pkg::*;

    localparam int MAX_TESTS = 64;

    logic               clk = 1'b0;
    logic               rst_n;
    logic [ID_W-1:0]    awid;
    logic [ADDR_W-1:0]  awaddr;
    logic [LEN_W-1:0]   awlen;
    logic [SIZE_W-1:0]  awsize;
    logic [BURST_W-1:0] awburst;
    logic               awvalid;
    logic               awready;
    logic [DATA_W-1:0]  wdata;
    logic [STRB_W-1:0]  wstrb;
    logic               wlast;
    logic               wvalid;
    logic               wready;
    logic [ID_W-1:0]    bid;
    logic [RESP_W-1:0]  bresp;
    logic               bvalid;
    logic               bready = 1'b1;
    logic               grant = 1'b0;
    logic               user_we;
    logic [ID_W-1:0]    user_id;
    logic [ADDR_W-1:0]  user_addr;
    logic [DATA_W-1:0]  user_data;
    logic [STRB_W-1:0]  user_strb;
    logic               user_last;

    // Golden table, one entry per burst
    int          n_tests;
    int          t_num [MAX_TESTS];
    int          t_id [MAX_TESTS];
    logic [31:0] t_addr [MAX_TESTS];
    int          t_len [MAX_TESTS];
    int          t_size [MAX_TESTS];
    int          t_burst [MAX_TESTS];
    int          t_grant [MAX_TESTS];
    int          t_hold [MAX_TESTS];
    int          t_resp [MAX_TESTS];
    int          test_err [MAX_TESTS];
    bit          any_hold;

    // Beats of the burst in flight
    logic [31:0] exp_data [256];
    logic [3:0]  exp_strb [256];
    // Bursts still waiting for their response
    int          exp_test_q [$];

    int          checks;
    int          errors;
    int          cycles;
    int          limit;
    int          hold_until;
    int          grant_mode;
    logic        wready_low_seen = 1'b0;
    logic [31:0] rng = 32'd27673;

    axi_wslv DUT (.*);

    always #20 clk = ~clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected address of beat k
    function automatic logic [31:0] beat_address(input logic [31:0] addr, input int size,
                                                 input int burst, input int k);
        int          eff;
        logic [31:0] aligned;
        logic [31:0] step;
        logic [31:0] page_end;
        eff = (size > BYTES_LOG2) ? BYTES_LOG2 : size;
        aligned = addr & ~((32'd1 << eff) - 32'd1);
        step = (burst == 0) ? 32'd0 : (32'd1 << eff);
        if (k == 0) begin
            return addr;
        end
        if (((aligned + k * step) >> PAGE_BIT) == (addr >> PAGE_BIT)) begin
            return aligned + k * step;
        end
        // Past the page end, stay on the last beat inside the page
        page_end = {addr[31:PAGE_BIT], {PAGE_BIT{1'b1}}};
        return aligned + ((page_end - aligned) / step) * step;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input int test_idx);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            if (test_idx >= 0) begin
                test_err[test_idx] = test_err[test_idx] + 1;
            end
            $display("MISMATCH at %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        errors = errors + 1;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic load_golden();
        int    fd;
        int    r;
        int    n;
        string line;
        fd = $fopen("axi_wslv_golden.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open axi_wslv_golden.txt");
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                r = $fgets(line, fd);
                // Skip comment and empty lines
                if (r > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %h %h %d %d %d %d %d %d", t_num[n_tests],
                                t_id[n_tests], t_addr[n_tests], t_len[n_tests],
                                t_size[n_tests], t_burst[n_tests], t_grant[n_tests],
                                t_hold[n_tests], t_resp[n_tests]);
                    if (n == 9) begin
                        limit = limit + t_len[n_tests] + 1 + 40;
                        any_hold = any_hold || (t_hold[n_tests] > 0);
                        n_tests = n_tests + 1;
                    end
                end
            end
            $fclose(fd);
        end
        limit = limit + 200;
    endtask

    // ------------------------------------------------------------------------
    // AXI master and user port monitor
    // ------------------------------------------------------------------------
    task automatic send_address(input int i);
        @(posedge clk);
        awvalid <= 1'b1;
        awid    <= ID_W'(t_id[i]);
        awaddr  <= t_addr[i];
        awlen   <= LEN_W'(t_len[i]);
        awsize  <= SIZE_W'(t_size[i]);
        awburst <= BURST_W'(t_burst[i]);
        do @(negedge clk); while (!awready);
        @(posedge clk);
        awvalid <= 1'b0;
    endtask

    task automatic send_data(input int len);
        @(posedge clk);
        for (int k = 0; k <= len; k++) begin
            wvalid <= 1'b1;
            wdata  <= exp_data[k];
            wstrb  <= exp_strb[k];
            wlast  <= (k == len);
            do @(negedge clk); while (!wready);
            @(posedge clk);
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
    endtask

    task automatic watch_beats(input int i);
        for (int k = 0; k <= t_len[i]; k++) begin
            do @(negedge clk); while (!user_we);
            check_value("user_addr", beat_address(t_addr[i], t_size[i], t_burst[i], k),
                        user_addr, i);
            check_value("user_data", exp_data[k], user_data, i);
            check_value("user_strb", exp_strb[k], user_strb, i);
            check_value("user_id", t_id[i], user_id, i);
            check_value("user_last", k == t_len[i], user_last, i);
        end
    endtask

    task automatic run_test(input int i);
        @(negedge clk);
        grant_mode = t_grant[i];
        if (t_hold[i] > 0) begin
            hold_until = cycles + t_hold[i];
        end
        for (int k = 0; k <= t_len[i]; k++) begin
            rng = xorshift(rng);
            exp_data[k] = rng;
            rng = xorshift(rng);
            exp_strb[k] = rng[3:0];
        end
        exp_test_q.push_back(i);
        fork
            send_address(i);
            send_data(t_len[i]);
            watch_beats(i);
        join
    endtask

    task automatic take_response();
        int idx;
        if (exp_test_q.size() == 0) begin
            report_failure("response returned with no burst outstanding");
        end else begin
            idx = exp_test_q.pop_front();
            check_value("bid", t_id[idx], bid, idx);
            check_value("bresp", t_resp[idx], bresp, idx);
            $display("test %0d: id %0h len %0d size %0d burst %0d grant %0d %0s",
                     t_num[idx], t_id[idx], t_len[idx], t_size[idx], t_burst[idx],
                     t_grant[idx], (test_err[idx] == 0) ? "ok" : "failed");
        end
    endtask

    // ------------------------------------------------------------------------
    // Cycle count, grant pattern and BREADY hold
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // Mode 1 alternates, mode 2 gives 5 low and 3 high
    always @(posedge clk) begin
        case (grant_mode)
            1:       grant <= ((cycles % 2) == 1);
            2:       grant <= ((cycles % 8) >= 5);
            default: grant <= 1'b1;
        endcase
        bready <= (cycles >= hold_until);
    end

    // Sampled mid-cycle, where DUT outputs are settled
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (!wready) begin
                wready_low_seen <= 1'b1;
            end
            if (user_we && !grant) begin
                report_failure("user_we high while grant is low");
            end
            if (bvalid && bready) begin
                take_response();
            end
        end
    end

    initial begin
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awsize  = '0;
        awburst = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        load_golden();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        // Drain responses still held back by BREADY
        while (exp_test_q.size() != 0) begin
            @(negedge clk);
        end
        // A long hold should have filled the W buffer
        if (any_hold) begin
            check_value("wready_low_seen", 1, wready_low_seen, -1);
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* axi_wslv_golden.txt */
# test id(hex) addr(hex) len size burst(0 FIXED, 1 INCR) grant(0 high, 1 toggle, 2 stretch)
# bready_hold(cycles) bresp(0 OKAY, 2 SLVERR)
1 1 00001000 3 2 1 0 0 0
2 2 00002001 5 1 1 0 0 0
3 3 00003003 7 0 1 0 0 0
4 4 00004006 0 2 1 0 0 0
5 5 00005010 15 2 1 0 0 0
6 6 00006024 3 2 0 0 0 0
7 7 00007002 4 1 0 0 0 0
8 8 00008000 0 0 0 0 0 0
9 9 00000ff0 7 2 1 0 0 0
10 a 00001ffa 5 1 1 0 0 0
11 b 00002ffe 3 0 1 0 0 0
12 c 00003f00 65 2 1 0 0 0
13 d 00000100 3 3 1 0 0 2
14 e 00000200 0 3 0 0 0 2
15 f 00000300 7 2 1 1 0 0
16 0 00000400 11 1 1 2 0 0
17 1 00000500 2 2 0 2 0 0
18 2 00000600 1 2 1 0 80 0
19 3 00000700 2 2 1 0 0 0
20 4 00000800 0 1 1 0 0 0
21 5 00000900 1 3 1 0 0 2
22 6 00000a00 2 0 1 0 0 0
23 7 00000b00 23 2 1 0 0 0
24 8 00000c01 2 2 1 1 0 0

/* src.f */
axi_wslv_pkg.sv
burst_addr_if.sv
sync_fifo.sv
burst_addr_gen.sv
wburst_ctrl.sv
axi_wslv.sv
tb_axi_wslv.sv

/* Bender.yml */
package:
  name: axi_wslv

sources:
  - axi_wslv_pkg.sv
  - burst_addr_if.sv
  - sync_fifo.sv
  - burst_addr_gen.sv
  - wburst_ctrl.sv
  - axi_wslv.sv
  - target: test
    files:
      - tb_axi_wslv.sv
